//--- vldu_top.f
+incdir+hdl
hdl/vldu_insn_pkg.sv
hdl/vldu_data_pkg.sv
hdl/vldu_insn_queue.sv
hdl/vldu_beat_packer.sv
hdl/vldu_result_queue.sv
hdl/vldu_top.sv
verification/vldu_chk.sv
verification/tb_vldu.sv

//--- Makefile
# Verilator simulation of the vector load unit

TOP := tb_vldu
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f vldu_top.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@grep -q "^TEST PASS$$" sim.log || (echo "Simulation failed"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ) sim.log

//--- verification/tb_vldu.sv
// Testbench of the vector load unit
// Clock, reset, sequencer, memory and lane models
// Watchdog and final verdict, checking is done by the bound checker

`include "vldu_config.svh"

module tb_vldu;

  localparam int unsigned NR_LANES = `VLDU_NR_LANES;
  localparam int unsigned NR_INSN  = 12;

  logic                                        clk = 1'b0;
  logic                                        rst_n;
  vldu_insn_pkg::pe_req_t                      pe_req;
  logic                                        pe_req_valid;
  logic                                        pe_req_ready;
  vldu_insn_pkg::pe_resp_t                     pe_resp;
  vldu_data_pkg::mem_beat_t                    mem_r;
  logic                                        mem_r_valid;
  logic                                        mem_r_ready;
  vldu_data_pkg::lane_result_t [NR_LANES-1:0]  ldu_result;
  logic [NR_LANES-1:0]                         ldu_result_req;
  logic [NR_LANES-1:0]                         ldu_result_gnt;
  logic                                        load_complete;

  // Loads and their memory beats, in issue order
  vldu_insn_pkg::pe_req_t  insns [$];
  logic [63:0]             beats [$];
  int unsigned             beat_idx = 0;
  logic                    beat_fire = 1'b0;
  int unsigned             done_cnt = 0;
  logic [31:0]             lfsr = 32'h225bae45;

  vldu_top uut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .pe_req_i         (pe_req),
    .pe_req_valid_i   (pe_req_valid),
    .pe_req_ready_o   (pe_req_ready),
    .pe_resp_o        (pe_resp),
    .mem_r_i          (mem_r),
    .mem_r_valid_i    (mem_r_valid),
    .mem_r_ready_o    (mem_r_ready),
    .ldu_result_o     (ldu_result),
    .ldu_result_req_o (ldu_result_req),
    .ldu_result_gnt_i (ldu_result_gnt),
    .load_complete_o  (load_complete)
  );

  always #10 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Queue a load and its beats, stream byte n of id holds {id, n[4:0]}
  task automatic add_insn(input logic [4:0] vd, input logic [5:0] vl,
                          input vldu_insn_pkg::vsew_e vsew);
    vldu_insn_pkg::pe_req_t req;
    int unsigned            total;
    logic [63:0]            data;
    req.id   = vldu_insn_pkg::vid_t'(insns.size());
    req.vd   = vd;
    req.vl   = vl;
    req.vsew = vsew;
    total    = int'(vl) << vsew;
    for (int unsigned b = 0; b * 8 < total; b++) begin
      for (int unsigned j = 0; j < 8; j++) begin
        data[8*j +: 8] = {req.id, 5'(b * 8 + j)};
      end
      beats.push_back(data);
    end
    insns.push_back(req);
  endtask

  // Hold the request until an edge sees ready
  task automatic send_insn(input vldu_insn_pkg::pe_req_t req);
    pe_req       = req;
    pe_req_valid = 1'b1;
    @(negedge clk);
    while (!pe_req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
  endtask

  always @(negedge clk) begin
    beat_fire = mem_r_valid && mem_r_ready;
    if (pe_resp.vinsn_done != '0) begin
      done_cnt++;
    end
  end

  // Memory and lane models, random gaps and grants
  always @(posedge clk) begin
    if (rst_n) begin
      #2;
      if (beat_fire) begin
        beat_idx++;
      end
      for (int l = 0; l < NR_LANES; l++) begin
        lfsr = lfsr_next(lfsr);
        ldu_result_gnt[l] = ldu_result_req[l] && lfsr[0];
      end
      // A pending beat stays valid until taken
      if (!mem_r_valid || beat_fire) begin
        lfsr = lfsr_next(lfsr);
        mem_r_valid = (beat_idx < beats.size()) && lfsr[0];
        if (beat_idx < beats.size()) begin
          mem_r.data = beats[beat_idx];
        end
      end
    end
  end

  initial begin : p_main
    rst_n          = 1'b0;
    pe_req         = '0;
    pe_req_valid   = 1'b0;
    mem_r          = '0;
    mem_r_valid    = 1'b0;
    ldu_result_gnt = '0;
    // Every width, partial beats and words, many registers
    add_insn(5'd1,  6'd32, vldu_insn_pkg::EW8);
    add_insn(5'd3,  6'd5,  vldu_insn_pkg::EW8);
    add_insn(5'd4,  6'd6,  vldu_insn_pkg::EW16);
    add_insn(5'd7,  6'd8,  vldu_insn_pkg::EW32);
    add_insn(5'd9,  6'd3,  vldu_insn_pkg::EW64);
    add_insn(5'd10, 6'd1,  vldu_insn_pkg::EW8);
    add_insn(5'd12, 6'd13, vldu_insn_pkg::EW16);
    add_insn(5'd15, 6'd5,  vldu_insn_pkg::EW32);
    add_insn(5'd2,  6'd4,  vldu_insn_pkg::EW64);
    add_insn(5'd14, 6'd20, vldu_insn_pkg::EW8);
    add_insn(5'd6,  6'd7,  vldu_insn_pkg::EW32);
    add_insn(5'd0,  6'd1,  vldu_insn_pkg::EW64);
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    foreach (insns[i]) begin
      send_insn(insns[i]);
    end
    pe_req_valid = 1'b0;
    wait (done_cnt == NR_INSN);
    repeat (4) @(posedge clk);
    if (uut.i_chk.fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "Checker reported %0d errors", uut.i_chk.fail_cnt);
    end
  end

  // Stop at the first failed assertion
  initial begin : p_fail_watch
    wait (uut.i_chk.fail_cnt != 0);
    $display("TEST FAIL");
    $fatal(1, "A checker assertion failed, see the error above");
  end

  initial begin : p_watchdog
    #(NR_INSN * 400 * 20);
    $display("Timeout with %0d of %0d loads completed", done_cnt, NR_INSN);
    $display("TEST FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- verification/vldu_chk.sv
// Bound checker of the vector load unit
// Records loads at acceptance, derives the expected lane payloads
// Concurrent assertions on data, address, id, stability, completion and flow control

`include "vldu_config.svh"

module vldu_chk (
  input logic                                             clk_i,
  input logic                                             rst_ni,
  input vldu_insn_pkg::pe_req_t                           pe_req_i,
  input logic                                             pe_req_valid_i,
  input logic                                             pe_req_ready_i,
  input vldu_insn_pkg::pe_resp_t                          pe_resp_i,
  input logic                                             mem_r_ready_i,
  input vldu_data_pkg::lane_result_t [`VLDU_NR_LANES-1:0] ldu_result_i,
  input logic [`VLDU_NR_LANES-1:0]                        ldu_result_req_i,
  input logic [`VLDU_NR_LANES-1:0]                        ldu_result_gnt_i,
  input logic                                             load_complete_i
);

  localparam int unsigned L = `VLDU_NR_LANES;

  // Byte count of one load
  function automatic int unsigned byte_total(input vldu_insn_pkg::pe_req_t req);
    return int'(req.vl) << req.vsew;
  endfunction

  // Stream index of byte o in word w of lane l, element size s
  function automatic int unsigned stream_idx(input int unsigned w, input int unsigned o,
                                             input int unsigned l, input int unsigned s);
    int unsigned p;
    p = w * 8 + o;
    return ((p / s) * L + l) * s + p % s;
  endfunction

  // Loads by id and ids in acceptance order
  vldu_insn_pkg::pe_req_t  insn_tab [`VLDU_NR_VINSN];
  vldu_insn_pkg::vid_t     order_q [16];
  int unsigned             acc_cnt;
  int unsigned             done_cnt;
  // Commit-order load and word index each lane is working on
  int unsigned             lane_idx [L];
  int unsigned             lane_word [L];
  int unsigned             inflight;
  int unsigned             fail_cnt = 0;
  vldu_insn_pkg::pe_req_t  lane_insn [L];
  logic [4:0]              exp_addr [L];
  logic [7:0]              exp_be [L];
  logic [63:0]             exp_data [L];
  logic [63:0]             be_mask [L];
  logic [`VLDU_NR_VINSN-1:0] exp_done;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  always_comb begin : p_expect
    int unsigned n;
    for (int l = 0; l < L; l++) begin
      lane_insn[l] = insn_tab[order_q[lane_idx[l] % 16]];
      // Two words per register
      exp_addr[l]  = 5'(lane_insn[l].vd * 2 + lane_word[l]);
      for (int o = 0; o < 8; o++) begin
        n = stream_idx(lane_word[l], o, l, 1 << lane_insn[l].vsew);
        exp_be[l][o]          = (n < byte_total(lane_insn[l]));
        exp_data[l][8*o +: 8] = {lane_insn[l].id, 5'(n)};
        be_mask[l][8*o +: 8]  = {8{ldu_result_i[l].be[o]}};
      end
    end
    exp_done = '0;
    exp_done[order_q[done_cnt % 16]] = 1'b1;
    // A done pulse this cycle already frees its slot
    inflight = acc_cnt - done_cnt - ((pe_resp_i.vinsn_done != '0) ? 1 : 0);
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i && pe_req_ready_i) begin
      insn_tab[pe_req_i.id] <= pe_req_i;
      order_q[acc_cnt % 16] <= pe_req_i.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_cnt  <= 0;
      done_cnt <= 0;
      for (int l = 0; l < L; l++) begin
        lane_idx[l]  <= 0;
        lane_word[l] <= 0;
      end
    end else begin
      if (pe_req_valid_i && pe_req_ready_i) begin
        acc_cnt <= acc_cnt + 1;
      end
      if (pe_resp_i.vinsn_done != '0) begin
        done_cnt <= done_cnt + 1;
      end
      // A lane moves on to the next load after its last word
      for (int l = 0; l < L; l++) begin
        if (ldu_result_req_i[l] && ldu_result_gnt_i[l]) begin
          if ((lane_word[l] + 1) * 16 >= byte_total(lane_insn[l])) begin
            lane_word[l] <= 0;
            lane_idx[l]  <= lane_idx[l] + 1;
          end else begin
            lane_word[l] <= lane_word[l] + 1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Lane checks
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < L; l++) begin : g_lane
    a_be: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ldu_result_req_i[l] && ldu_result_gnt_i[l] |-> ldu_result_i[l].be == exp_be[l])
      else begin
        fail_cnt++;
        $error("ERROR %0t ldu_result_o[%0d].be got %h expected %h", $time, l,
               $sampled(ldu_result_i[l].be), $sampled(exp_be[l]));
      end

    // Only enabled bytes carry data
    a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ldu_result_req_i[l] && ldu_result_gnt_i[l]
        |-> ((ldu_result_i[l].wdata ^ exp_data[l]) & be_mask[l]) == '0)
      else begin
        fail_cnt++;
        $error("ERROR %0t ldu_result_o[%0d].wdata got %h expected %h", $time, l,
               $sampled(ldu_result_i[l].wdata), $sampled(exp_data[l] & be_mask[l]));
      end

    a_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ldu_result_req_i[l] && ldu_result_gnt_i[l] |-> ldu_result_i[l].addr == exp_addr[l])
      else begin
        fail_cnt++;
        $error("ERROR %0t ldu_result_o[%0d].addr got %0d expected %0d", $time, l,
               $sampled(ldu_result_i[l].addr), $sampled(exp_addr[l]));
      end

    a_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ldu_result_req_i[l] && ldu_result_gnt_i[l]
        |-> lane_idx[l] < acc_cnt && ldu_result_i[l].id == lane_insn[l].id)
      else begin
        fail_cnt++;
        $error("ERROR %0t ldu_result_o[%0d].id got %0d expected %0d", $time, l,
               $sampled(ldu_result_i[l].id), $sampled(lane_insn[l].id));
      end

    // Request held with a frozen payload until the grant
    a_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ldu_result_req_i[l] && !ldu_result_gnt_i[l]
        |=> ldu_result_req_i[l] && $stable(ldu_result_i[l]))
      else begin
        fail_cnt++;
        $error("Lane %0d dropped its request or changed its payload before the grant", l);
      end
  end

  ////////////////////////////////////////////////////////////
  // Completion and flow control
  ////////////////////////////////////////////////////////////

  a_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_resp_i.vinsn_done != '0 |-> done_cnt < acc_cnt && pe_resp_i.vinsn_done == exp_done)
    else begin
      fail_cnt++;
      $error("ERROR %0t pe_resp_o got %b expected %b", $time,
             $sampled(pe_resp_i.vinsn_done), $sampled(exp_done));
    end

  a_complete: assert property (@(posedge clk_i) disable iff (!rst_ni)
      load_complete_i == (pe_resp_i.vinsn_done != '0))
    else begin
      fail_cnt++;
      $error("ERROR %0t load_complete_o got %b expected %b", $time,
             $sampled(load_complete_i), $sampled(pe_resp_i.vinsn_done != '0));
    end

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pe_req_ready_i == (inflight < 2))
    else begin
      fail_cnt++;
      $error("ERROR %0t pe_req_ready_o got %b expected %b", $time,
             $sampled(pe_req_ready_i), $sampled(inflight < 2));
    end

  // First sampled cycle out of reset
  a_reset: assert property (@(posedge clk_i)
      $rose(rst_ni) |-> pe_req_ready_i && !mem_r_ready_i && ldu_result_req_i == '0
                        && pe_resp_i.vinsn_done == '0 && !load_complete_i)
    else begin
      fail_cnt++;
      $error("Control outputs were not in their idle state right after reset");
    end

endmodule

bind vldu_top vldu_chk i_chk (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .pe_req_i         (pe_req_i),
  .pe_req_valid_i   (pe_req_valid_i),
  .pe_req_ready_i   (pe_req_ready_o),
  .pe_resp_i        (pe_resp_o),
  .mem_r_ready_i    (mem_r_ready_o),
  .ldu_result_i     (ldu_result_o),
  .ldu_result_req_i (ldu_result_req_o),
  .ldu_result_gnt_i (ldu_result_gnt_i),
  .load_complete_i  (load_complete_o)
);

//--- hdl/vldu_top.sv
// Top level of the vector load unit
// Instruction queue, beat packer and result queue

`include "vldu_config.svh"

module vldu_top (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // Sequencer
  input  vldu_insn_pkg::pe_req_t                           pe_req_i,
  input  logic                                             pe_req_valid_i,
  output logic                                             pe_req_ready_o,
  output vldu_insn_pkg::pe_resp_t                          pe_resp_o,
  // Memory read channel
  input  vldu_data_pkg::mem_beat_t                         mem_r_i,
  input  logic                                             mem_r_valid_i,
  output logic                                             mem_r_ready_o,
  // Lanes
  output vldu_data_pkg::lane_result_t [`VLDU_NR_LANES-1:0] ldu_result_o,
  output logic [`VLDU_NR_LANES-1:0]                        ldu_result_req_o,
  input  logic [`VLDU_NR_LANES-1:0]                        ldu_result_gnt_i,
  // Dispatcher
  output logic                                             load_complete_o
);

  // Issue path
  vldu_insn_pkg::pe_req_t   issue_insn;
  logic                     issue_valid;
  logic                     issue_done;
  // Packer to result queue
  logic                     push;
  vldu_data_pkg::rq_entry_t push_entry;
  logic                     rq_full;
  // Commit path
  logic                     commit_done;

  vldu_insn_queue i_insn_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .pe_req_ready_o  (pe_req_ready_o),
    .pe_resp_o       (pe_resp_o),
    .load_complete_o (load_complete_o),
    .issue_insn_o    (issue_insn),
    .issue_valid_o   (issue_valid),
    .issue_done_i    (issue_done),
    .commit_done_i   (commit_done)
  );

  vldu_beat_packer i_beat_packer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mem_r_i       (mem_r_i),
    .mem_r_valid_i (mem_r_valid_i),
    .mem_r_ready_o (mem_r_ready_o),
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .rq_full_i     (rq_full),
    .push_o        (push),
    .push_entry_o  (push_entry)
  );

  vldu_result_queue i_result_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .push_i           (push),
    .push_entry_i     (push_entry),
    .rq_full_o        (rq_full),
    .ldu_result_o     (ldu_result_o),
    .ldu_result_req_o (ldu_result_req_o),
    .ldu_result_gnt_i (ldu_result_gnt_i),
    .commit_done_o    (commit_done)
  );

endmodule

//--- hdl/vldu_result_queue.sv
// Result queue of the load unit
// Two-entry word queue with a valid bit per lane
// Pops on full grant and flags the commit of a load's last word

`include "vldu_config.svh"

module vldu_result_queue (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  // Packer
  input  logic                                             push_i,
  input  vldu_data_pkg::rq_entry_t                         push_entry_i,
  output logic                                             rq_full_o,
  // Lanes
  output vldu_data_pkg::lane_result_t [`VLDU_NR_LANES-1:0] ldu_result_o,
  output logic [`VLDU_NR_LANES-1:0]                        ldu_result_req_o,
  input  logic [`VLDU_NR_LANES-1:0]                        ldu_result_gnt_i,
  // Instruction queue
  output logic                                             commit_done_o
);

  localparam int unsigned DEPTH = `VLDU_RESULT_QUEUE_DEPTH;
  localparam int unsigned PNT_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Circular pointer step
  function automatic logic [PNT_W-1:0] next_pnt(input logic [PNT_W-1:0] pnt);
    return (pnt == PNT_W'(DEPTH - 1)) ? '0 : pnt + PNT_W'(1);
  endfunction

  vldu_data_pkg::rq_entry_t [DEPTH-1:0]  entry_q;
  // Lanes still owed each entry
  logic [DEPTH-1:0][`VLDU_NR_LANES-1:0]  valid_q, valid_d;
  logic [PNT_W-1:0]                      wr_pnt_q, wr_pnt_d;
  logic [PNT_W-1:0]                      rd_pnt_q, rd_pnt_d;
  logic [CNT_W-1:0]                      cnt_q, cnt_d;
  logic                                  pop;

  assign rq_full_o = (cnt_q == CNT_W'(DEPTH));

  ////////////////////////////////////////////////////////////
  // Lane side
  ////////////////////////////////////////////////////////////

  // Head entry, sliced per lane
  always_comb begin
    for (int unsigned l = 0; l < `VLDU_NR_LANES; l++) begin
      ldu_result_req_o[l]   = valid_q[rd_pnt_q][l];
      ldu_result_o[l].id    = entry_q[rd_pnt_q].id;
      ldu_result_o[l].addr  = entry_q[rd_pnt_q].addr;
      ldu_result_o[l].wdata = entry_q[rd_pnt_q].word.lanes[l];
      ldu_result_o[l].be    = entry_q[rd_pnt_q].be[l];
    end
  end

  ////////////////////////////////////////////////////////////
  // Queue state
  ////////////////////////////////////////////////////////////

  always_comb begin
    valid_d       = valid_q;
    wr_pnt_d      = wr_pnt_q;
    rd_pnt_d      = rd_pnt_q;
    pop           = 1'b0;
    commit_done_o = 1'b0;

    // Each lane drops its request on its own grant
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~ldu_result_gnt_i;

    // Head leaves once every lane took it
    if ((cnt_q != '0) && (valid_d[rd_pnt_q] == '0)) begin
      pop           = 1'b1;
      rd_pnt_d      = next_pnt(rd_pnt_q);
      commit_done_o = entry_q[rd_pnt_q].last;
    end

    // New word requests all lanes
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
      wr_pnt_d          = next_pnt(wr_pnt_q);
    end

    cnt_d = cnt_q + CNT_W'(push_i) - CNT_W'(pop);
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entry_q[wr_pnt_q] <= push_entry_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      wr_pnt_q <= wr_pnt_d;
      rd_pnt_q <= rd_pnt_d;
      cnt_q    <= cnt_d;
    end
  end

endmodule

//--- hdl/vldu_beat_packer.sv
// Beat packer of the load unit
// Places memory beat bytes into the VRF word by element width
// Tracks the remaining bytes and pushes words to the result queue

`include "vldu_config.svh"

module vldu_beat_packer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Memory read channel
  input  vldu_data_pkg::mem_beat_t   mem_r_i,
  input  logic                       mem_r_valid_i,
  output logic                       mem_r_ready_o,
  // Instruction queue
  input  vldu_insn_pkg::pe_req_t     issue_insn_i,
  input  logic                       issue_valid_i,
  output logic                       issue_done_o,
  // Result queue
  input  logic                       rq_full_i,
  output logic                       push_o,
  output vldu_data_pkg::rq_entry_t   push_entry_o
);

  localparam int unsigned BEAT_BYTES    = `VLDU_BEAT_BYTES;
  localparam int unsigned WORD_BYTES    = `VLDU_WORD_BYTES;
  // Byte count of one instruction, up to a full register
  localparam int unsigned CNT_W         = $clog2(`VLDU_VLEN / 8 + 1);
  localparam int unsigned WB_W          = $clog2(WORD_BYTES);
  localparam int unsigned LANE_W        = $clog2(`VLDU_NR_LANES);
  localparam int unsigned OFF_W         = $clog2(`VLDU_ELEN / 8);
  localparam int unsigned WORDS_PER_REG = `VLDU_VLEN / (8 * WORD_BYTES);

  // Sequential byte within a word to its lane-major byte index
  function automatic logic [WB_W-1:0] shuffle_idx(input logic [WB_W-1:0]    seq_byte,
                                                   input vldu_insn_pkg::vsew_e vsew);
    logic [WB_W-1:0] elem;
    logic [WB_W-1:0] elem_mask;
    logic [WB_W-1:0] in_lane;
    elem_mask = (WB_W'(1) << vsew) - WB_W'(1);
    // Element index, lanes take elements round robin
    elem      = seq_byte >> vsew;
    // Byte position inside the lane word
    in_lane   = ((elem >> LANE_W) << vsew) | (seq_byte & elem_mask);
    return {elem[LANE_W-1:0], in_lane[OFF_W-1:0]};
  endfunction

  // Bytes already packed for the current instruction
  logic [CNT_W-1:0]          byte_cnt_q, byte_cnt_d;
  logic [CNT_W-1:0]          total_bytes;
  logic [CNT_W-1:0]          rem_bytes;
  // Word under construction and its byte enables
  vldu_data_pkg::vrf_word_u  word_q, word_d;
  vldu_data_pkg::word_be_t   be_q, be_d;
  // Sequential write pointer after this beat
  logic [WB_W:0]             word_pnt_nxt;
  logic                      beat_fire;
  logic                      word_full;
  logic                      last_beat;

  ////////////////////////////////////////////////////////////
  // Beat acceptance
  ////////////////////////////////////////////////////////////

  assign total_bytes = CNT_W'(issue_insn_i.vl) << issue_insn_i.vsew;
  assign rem_bytes   = total_bytes - byte_cnt_q;

  // Beats only while a load is issued and the queue has room
  assign mem_r_ready_o = issue_valid_i && !rq_full_i;
  assign beat_fire     = mem_r_valid_i && mem_r_ready_o;

  assign word_pnt_nxt = {1'b0, byte_cnt_q[WB_W-1:0]} + (WB_W + 1)'(BEAT_BYTES);
  assign word_full    = (word_pnt_nxt == (WB_W + 1)'(WORD_BYTES));
  // This beat holds the final bytes of the load
  assign last_beat    = (rem_bytes <= CNT_W'(BEAT_BYTES));

  ////////////////////////////////////////////////////////////
  // Byte placement
  ////////////////////////////////////////////////////////////

  always_comb begin : p_pack
    logic [WB_W-1:0] vrf_byte;
    vrf_byte     = '0;
    word_d       = word_q;
    be_d         = be_q;
    byte_cnt_d   = byte_cnt_q;
    push_o       = 1'b0;
    issue_done_o = 1'b0;

    if (beat_fire) begin
      for (int unsigned j = 0; j < BEAT_BYTES; j++) begin
        // Bytes past the instruction end are dropped
        if (CNT_W'(j) < rem_bytes) begin
          vrf_byte = shuffle_idx(byte_cnt_q[WB_W-1:0] + WB_W'(j), issue_insn_i.vsew);
          word_d.bytes[vrf_byte] = mem_r_i.data[8*j +: 8];
          be_d[vrf_byte[WB_W-1 -: LANE_W]][vrf_byte[OFF_W-1:0]] = 1'b1;
        end
      end
      byte_cnt_d   = byte_cnt_q + CNT_W'(BEAT_BYTES);
      push_o       = word_full || last_beat;
      issue_done_o = last_beat;
    end

    // Entry carries the word including this beat
    push_entry_o.word = word_d;
    push_entry_o.be   = be_d;
    push_entry_o.id   = issue_insn_i.id;
    // Two words per register, word index from the packed byte count
    push_entry_o.addr = vldu_data_pkg::vaddr_t'(issue_insn_i.vd * WORDS_PER_REG
                                                + (byte_cnt_q >> WB_W));
    push_entry_o.last = last_beat;

    // Start a fresh word after a push
    if (push_o) begin
      word_d = '0;
      be_d   = '0;
    end
    // Next load starts from byte zero
    if (issue_done_o) begin
      byte_cnt_d = '0;
    end
  end

  always_ff @(posedge clk_i) begin
    word_q <= word_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q <= '0;
      be_q       <= '0;
    end else begin
      byte_cnt_q <= byte_cnt_d;
      be_q       <= be_d;
    end
  end

endmodule

//--- hdl/vldu_insn_queue.sv
// Instruction queue of the load unit
// Holds accepted loads with accept, issue and commit pointers
// Reports per-id done and the load-complete pulse

`include "vldu_config.svh"

module vldu_insn_queue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Sequencer
  input  vldu_insn_pkg::pe_req_t   pe_req_i,
  input  logic                     pe_req_valid_i,
  output logic                     pe_req_ready_o,
  output vldu_insn_pkg::pe_resp_t  pe_resp_o,
  output logic                     load_complete_o,
  // Packer
  output vldu_insn_pkg::pe_req_t   issue_insn_o,
  output logic                     issue_valid_o,
  input  logic                     issue_done_i,
  // Result queue
  input  logic                     commit_done_i
);

  localparam int unsigned DEPTH = `VLDU_INSN_QUEUE_DEPTH;
  localparam int unsigned PNT_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Pointers and occupancy counts
  typedef struct packed {
    logic [PNT_W-1:0] accept_pnt;
    logic [PNT_W-1:0] issue_pnt;
    logic [PNT_W-1:0] commit_pnt;
    // Waiting to be issued
    logic [CNT_W-1:0] issue_cnt;
    // Not yet committed
    logic [CNT_W-1:0] commit_cnt;
  } queue_state_t;

  // Circular pointer step
  function automatic logic [PNT_W-1:0] next_pnt(input logic [PNT_W-1:0] pnt);
    return (pnt == PNT_W'(DEPTH - 1)) ? '0 : pnt + PNT_W'(1);
  endfunction

  vldu_insn_pkg::pe_req_t [DEPTH-1:0] insn_q;
  queue_state_t                       state_q, state_d;
  vldu_insn_pkg::pe_resp_t            pe_resp_d;
  logic                               accept;

  ////////////////////////////////////////////////////////////
  // Accept and issue
  ////////////////////////////////////////////////////////////

  // Room while fewer than DEPTH loads are uncommitted
  assign pe_req_ready_o = (state_q.commit_cnt != CNT_W'(DEPTH));
  assign accept         = pe_req_valid_i && pe_req_ready_o;

  // Oldest unissued load goes to the packer
  assign issue_insn_o  = insn_q[state_q.issue_pnt];
  assign issue_valid_o = (state_q.issue_cnt != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[state_q.accept_pnt] <= pe_req_i;
    end
  end

  always_comb begin
    state_d = state_q;
    if (accept) begin
      state_d.accept_pnt = next_pnt(state_q.accept_pnt);
    end
    if (issue_done_i) begin
      state_d.issue_pnt = next_pnt(state_q.issue_pnt);
    end
    if (commit_done_i) begin
      state_d.commit_pnt = next_pnt(state_q.commit_pnt);
    end
    // Counts move with accept against issue or commit
    state_d.issue_cnt  = state_q.issue_cnt + CNT_W'(accept) - CNT_W'(issue_done_i);
    state_d.commit_cnt = state_q.commit_cnt + CNT_W'(accept) - CNT_W'(commit_done_i);
  end

  ////////////////////////////////////////////////////////////
  // Completion
  ////////////////////////////////////////////////////////////

  // Done bit of the id at the commit pointer
  always_comb begin
    pe_resp_d = '0;
    if (commit_done_i) begin
      pe_resp_d.vinsn_done[insn_q[state_q.commit_pnt].id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= '0;
      pe_resp_o       <= '0;
      load_complete_o <= 1'b0;
    end else begin
      state_q         <= state_d;
      // One-cycle pulses, registered
      pe_resp_o       <= pe_resp_d;
      load_complete_o <= commit_done_i;
    end
  end

endmodule

//--- hdl/vldu_data_pkg.sv
// Data-side types of the load unit
// Memory beat, lane result, VRF word union and result-queue entry

`include "vldu_config.svh"

package vldu_data_pkg;

  // VRF word address seen by the lanes
  typedef logic [4:0] vaddr_t;

  // Byte enables of one lane word
  typedef logic [`VLDU_ELEN/8-1:0] strb_t;

  // Byte enables of a full word, lane-major
  typedef logic [`VLDU_NR_LANES-1:0][`VLDU_ELEN/8-1:0] word_be_t;

  // One memory read beat, always full and aligned
  typedef struct packed {
    logic [`VLDU_BEAT_BYTES*8-1:0] data;
  } mem_beat_t;

  // Payload toward one lane, 80 bits
  typedef struct packed {
    vldu_insn_pkg::vid_t     id;
    vaddr_t                  addr;
    logic [`VLDU_ELEN-1:0]   wdata;
    strb_t                   be;
  } lane_result_t;

  // Full VRF word
  // Written byte by byte by the packer, read per lane by the result queue
  typedef union packed {
    logic [`VLDU_WORD_BYTES-1:0][7:0]           bytes;
    logic [`VLDU_NR_LANES-1:0][`VLDU_ELEN-1:0]  lanes;
  } vrf_word_u;

  // One result-queue entry
  typedef struct packed {
    vrf_word_u               word;
    word_be_t                be;
    vldu_insn_pkg::vid_t     id;
    vaddr_t                  addr;
    // Final word of its instruction
    logic                    last;
  } rq_entry_t;

endpackage

//--- hdl/vldu_insn_pkg.sv
// Sequencer-side types of the load unit
// Instruction id, element width, request and response

`include "vldu_config.svh"

package vldu_insn_pkg;

  // Vector instruction id
  typedef logic [$clog2(`VLDU_NR_VINSN)-1:0] vid_t;

  // Element width, element size is 2^vsew bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  // Load request from the sequencer, 16 bits
  typedef struct packed {
    vid_t        id;
    // Destination vector register
    logic [4:0]  vd;
    // Element count
    logic [5:0]  vl;
    vsew_e       vsew;
  } pe_req_t;

  // Done vector back to the sequencer, one bit per id
  typedef struct packed {
    logic [`VLDU_NR_VINSN-1:0] vinsn_done;
  } pe_resp_t;

endpackage

//--- hdl/vldu_config.svh
// Sizing macros of the vector load unit
// Lane count, data widths, register length, id count and queue depths

`ifndef VLDU_CONFIG_SVH
`define VLDU_CONFIG_SVH

// Number of lanes sharing one VRF word
`define VLDU_NR_LANES 2

// Lane word width in bits
`define VLDU_ELEN 64

// Bytes per memory read beat
`define VLDU_BEAT_BYTES 8

// Bytes per full VRF word, across all lanes
`define VLDU_WORD_BYTES 16

// Bits per vector register (two full words)
`define VLDU_VLEN 256

// Number of vector instruction ids
`define VLDU_NR_VINSN 8

// Queue depths
`define VLDU_INSN_QUEUE_DEPTH 2
`define VLDU_RESULT_QUEUE_DEPTH 2

`endif
